//--- Bender.yml
package:
  name: ice51

sources:
  - files:
      - src/ice51_pkg.sv
      - src/cpu_bus_if.sv
      - src/uart_loader.sv
      - src/uart_tx.sv
      - src/cpu_control.sv
      - src/cpu_datapath.sv
      - src/ice51_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_ice51.sv

//--- files.f
+incdir+verification
src/ice51_pkg.sv
src/cpu_bus_if.sv
src/uart_loader.sv
src/uart_tx.sv
src/cpu_control.sv
src/cpu_datapath.sv
src/ice51_top.sv
verification/tb_ice51.sv

//--- src/cpu_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cpu_bus_if;
   import ice51_pkg::*;

   // driven by the control unit
   instr_u            instr;       // latched opcode
   logic [DATA_W-1:0] op1;         // first operand byte
   logic [DATA_W-1:0] op2;         // second operand byte
   logic              exec;        // one cycle per instruction

   // driven by the datapath
   logic [DATA_W-1:0] acc;
   logic              carry;
   logic              acc_zero;

   modport ctrl (
      output instr, op1, op2, exec,
      input  carry, acc_zero
   );

   modport dp (
      input  instr, op1, op2, exec,
      output acc, carry, acc_zero
   );

endinterface

`default_nettype wire

//--- src/cpu_control.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_control (
   input  wire                             i_clk,
   input  wire                             i_nrst,
   input  wire                             i_load_done,
   input  wire [ice51_pkg::DATA_W-1:0]     i_code_data,
   input  wire [ice51_pkg::CODE_AW-1:0]    i_load_addr,
   output logic [ice51_pkg::CODE_AW-1:0]   o_code_addr,
   cpu_bus_if.ctrl                         bus
);
   import ice51_pkg::*;

   localparam logic [1:0] LEN1 = 2'd1;
   localparam logic [1:0] LEN2 = 2'd2;
   localparam logic [1:0] LEN3 = 2'd3;

   cpu_state_e              state;
   logic [CODE_AW-1:0]      pc;
   logic [CODE_AW-1:0]      pc_jump;
   logic [CODE_AW-1:0]      rel_tgt;
   logic [CODE_AW-1:0]      abs_tgt;
   instr_u                  instr_q;
   instr_u                  cur;       // opcode as seen this cycle
   logic [DATA_W-1:0]       op1_q;
   logic [DATA_W-1:0]       op2_q;
   logic [1:0]              len;

   // in DECODE0 the opcode is still on the code bus
   assign cur = (state == DECODE0) ? instr_u'(i_code_data) : instr_q;

   ////////////////////////////////////////////////////////////
   // instruction length

   always_comb begin
      case (cur.op)
         LJMP, MOV_DPTR: len = LEN3;
         MOV_A_IMM, ADD_A_IMM, ADDC_A_IMM, SUBB_A_IMM, XRL_A_IMM,
         SJMP, JZ, JNZ, JC, JNC: len = LEN2;
         default: len = LEN1;   // unknown opcodes too
      endcase
      if ({cur.rg.grp, 3'b000} == MOV_R_IMM) len = LEN2;
   end

   ////////////////////////////////////////////////////////////
   // jump targets

   // pc already points past the instruction in EXECUTE
   assign rel_tgt = pc + {{(CODE_AW - DATA_W){op1_q[DATA_W-1]}}, op1_q};
   assign abs_tgt = CODE_AW'({op1_q, op2_q});   // only the code space bits

   always_comb begin
      pc_jump = pc;
      case (instr_q.op)
         LJMP: pc_jump = abs_tgt;
         SJMP: pc_jump = rel_tgt;
         JZ:   if (bus.acc_zero)  pc_jump = rel_tgt;
         JNZ:  if (!bus.acc_zero) pc_jump = rel_tgt;
         JC:   if (bus.carry)     pc_jump = rel_tgt;
         JNC:  if (!bus.carry)    pc_jump = rel_tgt;
         default: ;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // fetch / decode / execute

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= FETCH;
         pc      <= '0;
         instr_q <= '0;
         op1_q   <= '0;
         op2_q   <= '0;
      end else begin
         case (state)
            FETCH: begin
               if (i_load_done) begin   // hold until program is in
                  pc    <= pc + 1'b1;
                  state <= DECODE0;
               end
            end
            DECODE0: begin
               instr_q <= cur;
               if (len != LEN1) begin
                  pc    <= pc + 1'b1;
                  state <= DECODE1;
               end else begin
                  state <= EXECUTE;
               end
            end
            DECODE1: begin
               op1_q <= i_code_data;
               if (len == LEN3) begin
                  pc    <= pc + 1'b1;
                  state <= DECODE2;
               end else begin
                  state <= EXECUTE;
               end
            end
            DECODE2: begin
               op2_q <= i_code_data;
               state <= EXECUTE;
            end
            EXECUTE: begin
               pc    <= pc_jump;
               state <= FETCH;
            end
            default: state <= FETCH;
         endcase
      end
   end

   assign o_code_addr = i_load_done ? pc : i_load_addr;

   assign bus.instr = instr_q;
   assign bus.op1   = op1_q;
   assign bus.op2   = op2_q;
   assign bus.exec  = (state == EXECUTE);

endmodule

`default_nettype wire

//--- src/cpu_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_datapath (
   input  wire                            i_clk,
   input  wire                            i_nrst,
   input  wire                            i_tx_busy,
   output logic                           o_tx_start,
   output logic [ice51_pkg::DATA_W-1:0]   o_tx_byte,
   cpu_bus_if.dp                          bus
);
   import ice51_pkg::*;

   localparam int RF_N = 8;   // r0..r7

   logic [DATA_W-1:0]     acc;
   logic                  carry;
   logic [DATA_W-1:0]     rf [RF_N];
   logic [2*DATA_W-1:0]   dptr;
   logic [DATA_W-1:0]     r_sel;
   logic [DATA_W-1:0]     grp_base;   // opcode with register index cleared
   logic [DATA_W-1:0]     add_src;
   logic                  add_cin;
   logic [DATA_W:0]       add_res;
   logic [DATA_W:0]       sub_res;
   logic                  stat_hit;
   logic [DATA_W-1:0]     acc_d;
   logic                  carry_d;
   logic [2*DATA_W-1:0]   dptr_d;
   logic                  rf_we;
   logic [DATA_W-1:0]     rf_d;

   assign r_sel    = rf[bus.instr.rg.idx];
   assign grp_base = {bus.instr.rg.grp, 3'b000};
   assign stat_hit = (dptr == UART_STAT_ADDR);

   ////////////////////////////////////////////////////////////
   // alu

   assign add_src = (grp_base == ADD_A_R) ? r_sel : bus.op1;
   assign add_cin = (bus.instr.op == ADDC_A_IMM) & carry;
   assign add_res = {1'b0, acc} + {1'b0, add_src} + {{DATA_W{1'b0}}, add_cin};
   assign sub_res = {1'b0, acc} - {1'b0, bus.op1} - {{DATA_W{1'b0}}, carry};   // msb = borrow

   always_comb begin
      acc_d   = acc;
      carry_d = carry;
      dptr_d  = dptr;
      rf_we   = 1'b0;
      rf_d    = acc;
      case (bus.instr.op)
         MOV_A_IMM:  acc_d = bus.op1;
         ADD_A_IMM,
         ADDC_A_IMM: {carry_d, acc_d} = add_res;
         SUBB_A_IMM: {carry_d, acc_d} = sub_res;
         XRL_A_IMM:  acc_d = acc ^ bus.op1;
         INC_A:      acc_d = acc + 1'b1;   // carry untouched
         DEC_A:      acc_d = acc - 1'b1;
         CLR_A:      acc_d = '0;
         CPL_A:      acc_d = ~acc;
         RLC_A:      {carry_d, acc_d} = {acc, carry};
         CLR_C:      carry_d = 1'b0;
         SETB_C:     carry_d = 1'b1;
         MOV_DPTR:   dptr_d = {bus.op1, bus.op2};
         // only the status location is mapped, the rest reads as zero
         MOVX_A_DPTR: acc_d = {{(DATA_W - 1){1'b0}}, i_tx_busy & stat_hit};
         default: ;
      endcase
      case (grp_base)
         MOV_R_IMM: begin
            rf_we = 1'b1;
            rf_d  = bus.op1;
         end
         MOV_R_A:   rf_we = 1'b1;
         MOV_A_R:   acc_d = r_sel;
         ADD_A_R:   {carry_d, acc_d} = add_res;
         INC_R: begin
            rf_we = 1'b1;
            rf_d  = r_sel + 1'b1;
         end
         DEC_R: begin
            rf_we = 1'b1;
            rf_d  = r_sel - 1'b1;
         end
         default: ;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // state, written at the end of EXECUTE only

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc   <= '0;
         carry <= 1'b0;
         dptr  <= '0;
         for (int i = 0; i < RF_N; i++) rf[i] <= '0;
      end else if (bus.exec) begin
         acc   <= acc_d;
         carry <= carry_d;
         dptr  <= dptr_d;
         if (rf_we) rf[bus.instr.rg.idx] <= rf_d;
      end
   end

   assign bus.acc      = acc;
   assign bus.carry    = carry;
   assign bus.acc_zero = (acc == '0);

   // movx @dptr,a to the transmit address
   assign o_tx_start = bus.exec & (bus.instr.op == MOVX_DPTR_A) & (dptr == UART_TX_ADDR);
   assign o_tx_byte  = bus.acc;

endmodule

`default_nettype wire

//--- src/ice51_pkg.sv
`default_nettype none

package ice51_pkg;

   ////////////////////////////////////////////////////////////
   // sizes

   localparam int CODE_AW    = 9;     // code address width
   localparam int DATA_W     = 8;
   localparam int PROG_BYTES = 512;   // bytes loaded before the core starts

   ////////////////////////////////////////////////////////////
   // uart

   localparam int UART_BIT_CYCLES = 104;
   localparam int UART_CNT_W      = $clog2(UART_BIT_CYCLES);

   localparam logic [15:0] UART_TX_ADDR   = 16'h0201;   // movx write sends acc
   localparam logic [15:0] UART_STAT_ADDR = 16'h0200;   // movx read gives busy

   // receiver states
   localparam logic [1:0] RX_IDLE  = 2'd0;
   localparam logic [1:0] RX_START = 2'd1;
   localparam logic [1:0] RX_DATA  = 2'd2;
   localparam logic [1:0] RX_STOP  = 2'd3;

   // transmitter states
   localparam logic [1:0] TX_IDLE  = 2'd0;
   localparam logic [1:0] TX_START = 2'd1;
   localparam logic [1:0] TX_SEND  = 2'd2;

   ////////////////////////////////////////////////////////////
   // instruction set

   // register forms are listed with r0, low 3 bits select the register
   typedef enum logic [7:0] {
      LJMP        = 8'h02,
      INC_A       = 8'h04,
      INC_R       = 8'h08,
      DEC_A       = 8'h14,
      DEC_R       = 8'h18,
      ADD_A_IMM   = 8'h24,
      ADD_A_R     = 8'h28,
      RLC_A       = 8'h33,
      ADDC_A_IMM  = 8'h34,
      JC          = 8'h40,
      JNC         = 8'h50,
      JZ          = 8'h60,
      XRL_A_IMM   = 8'h64,
      JNZ         = 8'h70,
      MOV_A_IMM   = 8'h74,
      MOV_R_IMM   = 8'h78,
      SJMP        = 8'h80,
      MOV_DPTR    = 8'h90,
      SUBB_A_IMM  = 8'h94,
      CLR_C       = 8'hC3,
      SETB_C      = 8'hD3,
      MOVX_A_DPTR = 8'hE0,
      CLR_A       = 8'hE4,
      MOV_A_R     = 8'hE8,
      MOVX_DPTR_A = 8'hF0,
      CPL_A       = 8'hF4,
      MOV_R_A     = 8'hF8
   } opcode_e;

   typedef enum logic [2:0] {
      FETCH   = 3'd0,
      DECODE0 = 3'd1,
      DECODE1 = 3'd2,
      DECODE2 = 3'd3,
      EXECUTE = 3'd4
   } cpu_state_e;

   // opcode byte, read whole or as group + register index
   typedef union packed {
      opcode_e op;
      struct packed {
         logic [4:0] grp;
         logic [2:0] idx;
      } rg;
   } instr_u;

endpackage

`default_nettype wire

//--- src/ice51_top.sv
`timescale 1ns/1ps
`default_nettype none

module ice51_top (
   input  wire                             i_clk,
   input  wire                             i_nrst,
   input  wire                             i_uart_rx,
   output logic                            o_uart_tx,
   output logic                            o_code_wr,
   output logic [ice51_pkg::CODE_AW-1:0]   o_code_addr,
   output logic [ice51_pkg::DATA_W-1:0]    o_code_data,
   input  wire  [ice51_pkg::DATA_W-1:0]    i_code_data
);
   import ice51_pkg::*;

   logic [CODE_AW-1:0] load_addr;
   logic               load_done;
   logic               tx_start;
   logic [DATA_W-1:0]  tx_byte;
   logic               tx_busy;

   cpu_bus_if bus_i ();

   uart_loader u_loader (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_uart_rx   (i_uart_rx),
      .o_code_wr   (o_code_wr),
      .o_code_data (o_code_data),
      .o_load_addr (load_addr),
      .o_load_done (load_done)
   );

   cpu_control u_ctrl (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_load_done (load_done),
      .i_code_data (i_code_data),
      .i_load_addr (load_addr),
      .o_code_addr (o_code_addr),
      .bus         (bus_i.ctrl)
   );

   cpu_datapath u_dp (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_tx_busy  (tx_busy),
      .o_tx_start (tx_start),
      .o_tx_byte  (tx_byte),
      .bus        (bus_i.dp)
   );

   uart_tx u_tx (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_start   (tx_start),
      .i_byte    (tx_byte),
      .o_uart_tx (o_uart_tx),
      .o_busy    (tx_busy)
   );

endmodule

`default_nettype wire

//--- src/uart_loader.sv
`timescale 1ns/1ps
`default_nettype none

module uart_loader (
   input  wire                             i_clk,
   input  wire                             i_nrst,
   input  wire                             i_uart_rx,
   output logic                            o_code_wr,
   output logic [ice51_pkg::DATA_W-1:0]    o_code_data,
   output logic [ice51_pkg::CODE_AW-1:0]   o_load_addr,
   output logic                            o_load_done
);
   import ice51_pkg::*;

   logic                  rx_meta;
   logic                  rx_sync;
   logic [1:0]            state;
   logic [UART_CNT_W-1:0] cnt;      // cycles within current bit
   logic [2:0]            bit_idx;
   logic [DATA_W-1:0]     shreg;
   logic [CODE_AW-1:0]    byte_cnt;
   logic                  done_q;
   logic                  half_hit;
   logic                  full_hit;
   logic                  rx_done;

   // two flops against metastability, line idles high
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= i_uart_rx;
         rx_sync <= rx_meta;
      end
   end

   assign half_hit = (cnt == UART_CNT_W'(UART_BIT_CYCLES / 2 - 1));
   assign full_hit = (cnt == UART_CNT_W'(UART_BIT_CYCLES - 1));
   assign rx_done  = (state == RX_STOP) && full_hit;   // middle of stop bit

   ////////////////////////////////////////////////////////////
   // receive fsm

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= RX_IDLE;
         cnt     <= '0;
         bit_idx <= '0;
      end else begin
         cnt <= cnt + 1'b1;
         case (state)
            RX_IDLE: begin
               cnt <= '0;
               if (!rx_sync) state <= RX_START;
            end
            RX_START: begin
               if (half_hit) begin
                  cnt     <= '0;
                  bit_idx <= '0;
                  state   <= rx_sync ? RX_IDLE : RX_DATA;   // glitch goes back
               end
            end
            RX_DATA: begin
               if (full_hit) begin
                  cnt     <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) state <= RX_STOP;
               end
            end
            RX_STOP: begin
               if (full_hit) begin
                  cnt   <= '0;
                  state <= RX_IDLE;
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // lsb arrives first
   always_ff @(posedge i_clk) begin
      if (state == RX_DATA && full_hit) shreg <= {rx_sync, shreg[DATA_W-1:1]};
   end

   ////////////////////////////////////////////////////////////
   // byte count and load done

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         byte_cnt <= '0;
         done_q   <= 1'b0;
      end else if (rx_done) begin
         byte_cnt <= byte_cnt + 1'b1;   // wraps at PROG_BYTES
         if (byte_cnt == CODE_AW'(PROG_BYTES - 1)) done_q <= 1'b1;
      end
   end

   assign o_code_wr   = rx_done & ~done_q;
   assign o_code_data = shreg;
   assign o_load_addr = byte_cnt;
   assign o_load_done = done_q;

endmodule

`default_nettype wire

//--- src/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
   input  wire                          i_clk,
   input  wire                          i_nrst,
   input  wire                          i_start,
   input  wire [ice51_pkg::DATA_W-1:0]  i_byte,
   output logic                         o_uart_tx,
   output logic                         o_busy
);
   import ice51_pkg::*;

   logic [1:0]            state;
   logic [UART_CNT_W-1:0] cnt;
   logic [3:0]            bit_cnt;    // 8 data bits then stop
   logic [DATA_W-1:0]     shreg;
   logic                  period_end;

   assign period_end = (cnt == UART_CNT_W'(UART_BIT_CYCLES - 1));

   ////////////////////////////////////////////////////////////
   // transmit fsm

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= TX_IDLE;
         cnt     <= '0;
         bit_cnt <= '0;
      end else begin
         cnt <= cnt + 1'b1;
         case (state)
            TX_IDLE: begin
               cnt     <= '0;
               bit_cnt <= '0;
               if (i_start) state <= TX_START;
            end
            TX_START: begin
               if (period_end) begin
                  cnt   <= '0;
                  state <= TX_SEND;
               end
            end
            TX_SEND: begin
               if (period_end) begin
                  cnt     <= '0;
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == 4'd8) state <= TX_IDLE;   // stop bit done
               end
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

   // shift right, ones fill in behind so the stop bit comes out last
   always_ff @(posedge i_clk) begin
      if (state == TX_IDLE && i_start) begin
         shreg <= i_byte;
      end else if (state == TX_SEND && period_end) begin
         shreg <= {1'b1, shreg[DATA_W-1:1]};
      end
   end

   always_comb begin
      case (state)
         TX_START: o_uart_tx = 1'b0;
         TX_SEND:  o_uart_tx = shreg[0];
         default:  o_uart_tx = 1'b1;    // idle line
      endcase
   end

   assign o_busy = (state != TX_IDLE);

endmodule

`default_nettype wire

//--- verification/tb_iss.svh
`ifndef TB_ISS_SVH
`define TB_ISS_SVH

////////////////////////////////////////////////////////////
// program image

function automatic void put(input logic [7:0] b);
   image[put_ptr] = b;
   put_ptr++;
endfunction

// n bytes, first byte in the highest used position
function automatic void put_code(input int n, input logic [63:0] seq);
   for (int i = n - 1; i >= 0; i--) begin
      put(seq[8*i +: 8]);
   end
endfunction

// wait for the transmitter, then send acc (r7 is scratch)
function automatic void put_send();
   put(8'hFF);                                 // mov r7,a
   put_code(3, 64'h90_02_00);                  // status address
   put(8'hE0);                                 // poll busy
   put_code(2, 64'h70_FD);                     // jnz back to poll
   put(8'hEF);                                 // mov a,r7
   put_code(3, 64'h90_02_01);
   put(8'hF0);                                 // movx @dptr,a starts tx
endfunction

function automatic void code_then_send(input int n, input logic [63:0] seq);
   put_code(n, seq);
   put_send();
endfunction

function automatic void build_image();
   int loop_adr;
   for (int i = 0; i < 512; i++) begin
      image[i] = 8'($random(seed));
   end
   put_ptr = 0;
   code_then_send(2, 64'h74_5A);               // mov a,#imm
   code_then_send(2, 64'h24_C3);               // add with carry out
   code_then_send(2, 64'h34_10);               // addc
   code_then_send(2, 64'h94_40);               // subb with borrow
   code_then_send(2, 64'h64_FF);               // xrl
   code_then_send(1, 64'h33);                  // rlc
   code_then_send(2, 64'hD3_33);
   code_then_send(3, 64'h04_04_14);
   code_then_send(1, 64'hF4);                  // cpl
   code_then_send(7, 64'h7A_33_0A_0A_1A_EA_2A);   // r2 ops
   code_then_send(4, 64'hFD_0D_ED_2D);
   // each conditional jump skips a mov a,#imm when taken
   code_then_send(5, 64'hE4_60_02_74_11);
   code_then_send(4, 64'h70_02_74_22);
   code_then_send(4, 64'h60_02_74_33);
   code_then_send(5, 64'hD3_40_02_74_44);
   code_then_send(4, 64'h50_02_74_55);
   code_then_send(5, 64'hC3_50_02_74_66);
   code_then_send(4, 64'h40_02_74_77);
   code_then_send(4, 64'h80_02_74_88);
   // countdown loop with a backward jnz
   put_code(2, 64'h7B_03);
   loop_adr = put_ptr;
   code_then_send(2, 64'h1B_EB);
   put_code(2, 64'hEB_70);
   put(8'(loop_adr - (put_ptr + 1)));
   put_code(3, 64'h02_01_C0);                  // ljmp forward
   put_ptr = 9'h1C0;
   code_then_send(2, 64'h74_A5);
   put_code(3, 64'h02_01_80);                  // ljmp backward
   put_ptr = 9'h180;
   code_then_send(2, 64'h74_3C);
   put_code(2, 64'h80_FE);                     // park here
endfunction

////////////////////////////////////////////////////////////
// reference model that fills exp_q with the transmitted bytes

function automatic void run_reference();
   logic [8:0]  pc;
   logic [8:0]  npc;
   logic [8:0]  rel;
   logic [7:0]  op;
   logic [7:0]  b1;
   logic [7:0]  b2;
   logic [7:0]  a;
   logic [7:0]  r [8];
   logic [15:0] dp;
   logic        c;
   logic        jmp;
   pc = 0;
   a  = 0;
   c  = 0;
   dp = 0;
   for (int i = 0; i < 8; i++) r[i] = 0;
   for (int step = 0; step < 100000; step++) begin
      op  = image[pc];
      b1  = image[9'(pc + 1)];
      b2  = image[9'(pc + 2)];
      npc = pc + 9'd1;
      if (op == 8'h02 || op == 8'h90) npc = pc + 9'd3;
      else if (op inside {8'h74, 8'h24, 8'h34, 8'h94, 8'h64, 8'h80, 8'h60, 8'h70,
                          8'h40, 8'h50} || op[7:3] == 5'h0F) npc = pc + 9'd2;
      rel = npc + {b1[7], b1};
      jmp = 0;
      case (op)
         8'h74: a = b1;
         8'h24: {c, a} = a + b1;
         8'h34: {c, a} = a + b1 + c;
         8'h94: {c, a} = {1'b0, a} - {1'b0, b1} - c;
         8'h64: a = a ^ b1;
         8'h04: a = a + 1;
         8'h14: a = a - 1;
         8'hE4: a = 0;
         8'hF4: a = ~a;
         8'h33: {c, a} = {a, c};
         8'hC3: c = 0;
         8'hD3: c = 1;
         8'h90: dp = {b1, b2};
         8'hE0: a = 0;                          // model never sees busy
         8'hF0: if (dp == 16'h0201) exp_q.push_back(a);
         8'h02: npc = {b1[0], b2};
         8'h80: jmp = 1;
         8'h60: jmp = (a == 0);
         8'h70: jmp = (a != 0);
         8'h40: jmp = c;
         8'h50: jmp = !c;
         default: begin
            case (op[7:3])
               5'h0F: r[op[2:0]] = b1;
               5'h1D: a = r[op[2:0]];
               5'h1F: r[op[2:0]] = a;
               5'h01: r[op[2:0]] = r[op[2:0]] + 1;
               5'h03: r[op[2:0]] = r[op[2:0]] - 1;
               5'h05: {c, a} = a + r[op[2:0]];
               default: ;
            endcase
         end
      endcase
      if (jmp) npc = rel;
      if (npc == pc) break;                     // jump to itself ends the program
      pc = npc;
   end
endfunction

`endif

//--- verification/tb_ice51.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ice51;
   import ice51_pkg::*;

   logic       clk;
   logic       nrst;
   logic       uart_rx;
   logic       uart_tx;
   logic       code_wr;
   logic [8:0] code_addr;
   logic [7:0] code_wdata;
   logic [7:0] code_rdata;

   logic [7:0] image [512];
   logic [7:0] mem [512];
   logic [7:0] exp_q [$];
   logic [7:0] rx_q [$];
   integer     seed;
   int         put_ptr;
   int         wr_count;
   int         load_errs;
   int         uart_errs;
   int         other_errs;
   logic       tx_started;
   logic       cmp_done;
   logic       run_end;

   `include "tb_iss.svh"

   ice51_top dut (
      .i_clk       (clk),
      .i_nrst      (nrst),
      .i_uart_rx   (uart_rx),
      .o_uart_tx   (uart_tx),
      .o_code_wr   (code_wr),
      .o_code_addr (code_addr),
      .o_code_data (code_wdata),
      .i_code_data (code_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // code memory with a one cycle read

   always @(posedge clk) code_rdata <= mem[code_addr];

   always @(negedge clk) begin
      if (code_wr) begin
         if (!tx_started || wr_count >= 512) begin
            $display("unexpected code write at %0t ns", $time);
            load_errs++;
         end else begin
            if (code_addr !== 9'(wr_count)) begin
               $display("mismatch at %0t ns: o_code_addr got %h expected %h",
                        $time, code_addr, 9'(wr_count));
               load_errs++;
            end
            if (code_wdata !== image[wr_count]) begin
               $display("mismatch at %0t ns: o_code_data got %h expected %h",
                        $time, code_wdata, image[wr_count]);
               load_errs++;
            end
         end
         mem[code_addr] = code_wdata;
         wr_count++;
      end
   end

   task automatic send_byte(input logic [7:0] b);
      uart_rx <= 1'b0;                          // start bit
      repeat (UART_BIT_CYCLES) @(posedge clk);
      for (int i = 0; i < 8; i++) begin
         uart_rx <= b[i];
         repeat (UART_BIT_CYCLES) @(posedge clk);
      end
      uart_rx <= 1'b1;
      repeat (UART_BIT_CYCLES) @(posedge clk);
   endtask

   // samples near both ends of every bit, so short bits are caught
   task automatic receive_frame();
      logic [7:0] b;
      logic       exp_lvl;
      int         bit_n;
      int         off;
      b = '0;
      for (int c = 0; c < 10 * UART_BIT_CYCLES; c++) begin
         if (c > 0) @(negedge clk);
         bit_n = c / UART_BIT_CYCLES;
         off   = c % UART_BIT_CYCLES;
         if (off == 1 && bit_n >= 1 && bit_n <= 8) b[bit_n - 1] = uart_tx;
         exp_lvl = (bit_n == 0) ? 1'b0 : (bit_n == 9) ? 1'b1 : b[bit_n - 1];
         if ((off == 1 || off == UART_BIT_CYCLES - 2) && uart_tx !== exp_lvl) begin
            $display("mismatch at %0t ns: o_uart_tx frame bit %0d got %b expected %b",
                     $time, bit_n, uart_tx, exp_lvl);
            uart_errs++;
         end
      end
      rx_q.push_back(b);
   endtask

   initial begin : monitor
      @(posedge nrst);
      while (!run_end) begin
         @(negedge clk);
         if (uart_tx === 1'b0) receive_frame();
      end
   end

   initial begin : compare
      int waited;
      logic [7:0] got;
      cmp_done = 1'b0;
      @(posedge nrst);
      for (int k = 0; k < exp_q.size(); k++) begin
         waited = 0;
         while (rx_q.size() == 0 && waited < 700000) begin
            @(negedge clk);
            waited++;
         end
         if (rx_q.size() == 0) begin
            $display("no byte %0d from the UART before the timeout", k);
            other_errs++;
            break;
         end
         got = rx_q.pop_front();
         if (got !== exp_q[k]) begin
            $display("mismatch at %0t ns: o_uart_tx byte %0d got %h expected %h",
                     $time, k, got, exp_q[k]);
            uart_errs++;
         end
      end
      cmp_done = 1'b1;
   end

   initial begin
      int waited;
      uart_rx    = 1'b1;
      code_rdata = '0;
      nrst       = 1'b0;
      seed       = 22073;
      wr_count   = 0;
      load_errs  = 0;
      uart_errs  = 0;
      other_errs = 0;
      tx_started = 1'b0;
      run_end    = 1'b0;
      build_image();
      run_reference();
      repeat (3) @(posedge clk);
      nrst <= 1'b1;
      @(negedge clk);
      if (uart_tx !== 1'b1) begin
         $display("mismatch at %0t ns: o_uart_tx got %b expected 1", $time, uart_tx);
         uart_errs++;
      end
      @(posedge clk);
      tx_started = 1'b1;
      for (int i = 0; i < 512; i++) send_byte(image[i]);
      repeat (10) @(posedge clk);
      if (wr_count != 512) begin
         $display("mismatch at %0t ns: o_code_wr count got %0d expected 512",
                  $time, wr_count);
         load_errs++;
      end
      waited = 0;
      while (!cmp_done && waited < 2000000) begin
         @(posedge clk);
         waited++;
      end
      if (!cmp_done) begin
         $display("compare process did not finish before the timeout");
         other_errs++;
      end
      repeat (3 * 10 * UART_BIT_CYCLES) @(posedge clk);
      if (rx_q.size() != 0) begin
         $display("the DUT sent %0d bytes more than expected", rx_q.size());
         uart_errs++;
      end
      run_end = 1'b1;
      $display("errors: load %0d, uart %0d, other %0d, bytes expected %0d",
               load_errs, uart_errs, other_errs, exp_q.size());
      if (load_errs + uart_errs + other_errs == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
